//--- hdl/buck_config.svh
`ifndef BUCK_CONFIG_SVH
`define BUCK_CONFIG_SVH

// Number of converter phases, a power of two from 2 to 8
`define N_PHASES 4

// PWM channels inside one phase block
`define N_CHANNELS 2

// The global control register sits at the base, phase p at base + (p + 1) * 'h100
`define PWM_BASE_ADDR 32'h0000_0000

// Byte offsets inside a phase block
`define DEAD_TIME_OFFSET 0
`define DUTY_OFFSET 8
`define PERIOD_OFFSET (4 * (3 * `N_CHANNELS + 1))
`define PHASE_SHIFT_OFFSET (4 * (3 * `N_CHANNELS + 2))

// Control word that enables the modulator
`define MODULATOR_ON_WORD 32'h28

`endif

//--- hdl/buck_pkg.sv
`include "buck_config.svh"

package buck_pkg;

    // Register write bus
    typedef logic [31:0] bus_address_t;
    typedef logic [31:0] bus_data_t;

    // Period, phase shift, duty or dead time of one phase
    typedef logic [15:0] phase_value_t;

    typedef logic [$clog2(`N_PHASES)-1:0] phase_index_t;

    typedef enum logic [2:0] {
        idle,
        wait_configuration,
        update_period,
        update_phase_shift,
        update_duty,
        start_modulator,
        wait_write_end
    } operating_state_t;

endpackage

//--- hdl/pwm_config_sequencer.sv
`timescale 1ns/1ns
`include "buck_config.svh"

module pwm_config_sequencer (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  buck_pkg::phase_value_t dead_time,
    output logic                   write_valid,
    output buck_pkg::bus_address_t write_address,
    output buck_pkg::bus_data_t    write_data,
    input  logic                   write_ready,
    output logic                   config_done
);
    import buck_pkg::*;

    typedef enum logic {
        seq_idle,
        seq_write
    } sequencer_state_t;

    sequencer_state_t state;
    phase_index_t     phase_count;
    phase_value_t     dead_time_q;

    // Dead-time register of the phase block the counter points at
    assign write_address = `PWM_BASE_ADDR + bus_address_t'(`DEAD_TIME_OFFSET)
                         + ((bus_address_t'(phase_count) + 32'd1) << 8);
    assign write_data    = bus_data_t'(dead_time_q);
    assign write_valid   = (state == seq_write);

    // The same dead time goes to every phase, so it is captured once at start
    always_ff @(posedge clock) begin
        if (state == seq_idle && start) begin
            dead_time_q <= dead_time;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state       <= seq_idle;
            phase_count <= '0;
            config_done <= 1'b0;
        end else begin
            config_done <= 1'b0;
            case (state)
                seq_idle: begin
                    if (start) begin
                        phase_count <= '0;
                        state       <= seq_write;
                    end
                end
                seq_write: begin
                    if (write_ready) begin
                        if (phase_count == phase_index_t'(`N_PHASES - 1)) begin
                            // Last dead time accepted, hand over to the core
                            phase_count <= '0;
                            config_done <= 1'b1;
                            state       <= seq_idle;
                        end else begin
                            phase_count <= phase_count + 1'b1;
                        end
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

endmodule

//--- hdl/buck_operating_core.sv
`timescale 1ns/1ns
`include "buck_config.svh"

module buck_operating_core (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   stop,
    input  logic                   update,
    input  logic                   config_done,
    input  buck_pkg::phase_value_t period,
    input  buck_pkg::phase_value_t duty [`N_PHASES],
    input  buck_pkg::phase_value_t phase_shifts [`N_PHASES],
    output logic                   write_valid,
    output buck_pkg::bus_address_t write_address,
    output buck_pkg::bus_data_t    write_data,
    input  logic                   write_ready,
    output logic                   modulator_status,
    output logic                   duty_echo_valid,
    output buck_pkg::phase_index_t duty_echo_phase,
    output buck_pkg::phase_value_t duty_echo_value
);
    import buck_pkg::*;

    operating_state_t state;
    operating_state_t next_state;
    operating_state_t pass_next;
    phase_index_t     phase_count;
    logic             last_phase;
    logic             write_free;
    logic             start_needed;
    logic             stop_request;
    bus_address_t     pass_offset;
    phase_value_t     pass_value;

    function automatic bus_address_t phase_address(input bus_address_t offset,
                                                   input phase_index_t phase);
        return `PWM_BASE_ADDR + offset + ((bus_address_t'(phase) + 32'd1) << 8);
    endfunction

    assign last_phase = (phase_count == phase_index_t'(`N_PHASES - 1));

    // A new write may be loaded when nothing is pending or the pending one completes now
    assign write_free = !write_valid || write_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Per-phase write passes

    always_comb begin
        pass_offset = bus_address_t'(`DUTY_OFFSET);
        pass_value  = duty[phase_count];
        pass_next   = start_needed ? start_modulator : idle;
        case (state)
            update_period: begin
                pass_offset = bus_address_t'(`PERIOD_OFFSET);
                pass_value  = period;
                pass_next   = update_phase_shift;
            end
            update_phase_shift: begin
                pass_offset = bus_address_t'(`PHASE_SHIFT_OFFSET);
                pass_value  = phase_shifts[phase_count];
                pass_next   = update_duty;
            end
            default: ;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Operating FSM

    always_ff @(posedge clock) begin
        if (!reset) begin
            state            <= idle;
            next_state       <= idle;
            phase_count      <= '0;
            write_valid      <= 1'b0;
            modulator_status <= 1'b0;
            start_needed     <= 1'b0;
            stop_request     <= 1'b0;
            duty_echo_valid  <= 1'b0;
        end else begin
            duty_echo_valid <= 1'b0;
            case (state)
                idle: begin
                    // A pending stop wins over start and update
                    if (stop_request) begin
                        write_address    <= `PWM_BASE_ADDR;
                        write_data       <= '0;
                        write_valid      <= 1'b1;
                        modulator_status <= 1'b0;
                        stop_request     <= 1'b0;
                        next_state       <= idle;
                        state            <= wait_write_end;
                    end else if (start) begin
                        start_needed <= 1'b1;
                        state        <= wait_configuration;
                    end else if (update && modulator_status) begin
                        state <= update_phase_shift;
                    end
                end
                wait_configuration: begin
                    if (config_done) begin
                        state <= update_period;
                    end
                end
                start_modulator: begin
                    write_address    <= `PWM_BASE_ADDR;
                    write_data       <= `MODULATOR_ON_WORD;
                    write_valid      <= 1'b1;
                    modulator_status <= 1'b1;
                    start_needed     <= 1'b0;
                    next_state       <= idle;
                    state            <= wait_write_end;
                end
                wait_write_end: begin
                    if (write_ready) begin
                        write_valid <= 1'b0;
                        state       <= next_state;
                    end
                end
                default: begin
                    // update_period, update_phase_shift and update_duty
                    if (write_free) begin
                        write_address <= phase_address(pass_offset, phase_count);
                        write_data    <= bus_data_t'(pass_value);
                        write_valid   <= 1'b1;
                        if (state == update_duty) begin
                            duty_echo_valid <= 1'b1;
                            duty_echo_phase <= phase_count;
                            duty_echo_value <= pass_value;
                        end
                        if (last_phase) begin
                            phase_count <= '0;
                            next_state  <= pass_next;
                            state       <= wait_write_end;
                        end else begin
                            phase_count <= phase_count + 1'b1;
                        end
                    end
                end
            endcase

            // Stop may arrive in any state and waits for idle
            if (stop) begin
                stop_request <= 1'b1;
            end
        end
    end

endmodule

//--- hdl/register_write_arbiter.sv
`timescale 1ns/1ns

module register_write_arbiter (
    input  logic                   sequencer_valid,
    input  buck_pkg::bus_address_t sequencer_address,
    input  buck_pkg::bus_data_t    sequencer_data,
    output logic                   sequencer_ready,
    input  logic                   core_valid,
    input  buck_pkg::bus_address_t core_address,
    input  buck_pkg::bus_data_t    core_data,
    output logic                   core_ready,
    output logic                   bus_valid,
    output buck_pkg::bus_address_t bus_address,
    output buck_pkg::bus_data_t    bus_data,
    input  logic                   bus_ready
);

    logic sequencer_grant;

    // The sequencer always has priority, the core gets the bus otherwise
    assign sequencer_grant = sequencer_valid;

    assign bus_valid   = sequencer_grant ? sequencer_valid : core_valid;
    assign bus_address = sequencer_grant ? sequencer_address : core_address;
    assign bus_data    = sequencer_grant ? sequencer_data : core_data;

    // Only the granted writer sees the bank's ready
    assign sequencer_ready = sequencer_grant && bus_ready;
    assign core_ready      = !sequencer_grant && bus_ready;

endmodule

//--- hdl/pwm_register_bank.sv
`timescale 1ns/1ns
`include "buck_config.svh"

module pwm_register_bank (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_valid,
    input  buck_pkg::bus_address_t write_address,
    input  buck_pkg::bus_data_t    write_data,
    output logic                   write_ready,
    input  buck_pkg::bus_address_t read_address,
    output buck_pkg::bus_data_t    read_data
);
    import buck_pkg::*;

    typedef enum logic [2:0] {
        field_none,
        field_control,
        field_dead_time,
        field_period,
        field_phase_shift,
        field_duty
    } field_t;

    bus_data_t    control_reg;
    phase_value_t dead_time_reg [`N_PHASES];
    phase_value_t period_reg [`N_PHASES];
    phase_value_t phase_shift_reg [`N_PHASES];
    phase_value_t duty_reg [`N_PHASES];
    field_t       write_field;
    field_t       read_field;
    phase_index_t write_phase;
    phase_index_t read_phase;
    logic         write_accept;

    ////////////////////////////////////////////////////////////////////////////
    // Address decode, shared by the write and the read side

    function automatic field_t decode_field(input bus_address_t address);
        bus_address_t relative;
        relative = address - `PWM_BASE_ADDR;
        if (relative == '0) begin
            return field_control;
        end
        if (relative[31:8] == '0 || relative[31:8] > 24'(`N_PHASES)) begin
            return field_none;
        end
        case (relative[7:0])
            8'(`DEAD_TIME_OFFSET):   return field_dead_time;
            8'(`PERIOD_OFFSET):      return field_period;
            8'(`PHASE_SHIFT_OFFSET): return field_phase_shift;
            8'(`DUTY_OFFSET):        return field_duty;
            default:                 return field_none;
        endcase
    endfunction

    // Block 1 holds phase 0
    function automatic phase_index_t decode_phase(input bus_address_t address);
        bus_address_t relative;
        relative = address - `PWM_BASE_ADDR;
        return phase_index_t'(relative[31:8] - 24'd1);
    endfunction

    assign write_field  = decode_field(write_address);
    assign write_phase  = decode_phase(write_address);
    assign read_field   = decode_field(read_address);
    assign read_phase   = decode_phase(read_address);
    assign write_accept = write_valid && write_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Register storage

    always_ff @(posedge clock) begin
        if (!reset) begin
            write_ready <= 1'b1;
            control_reg <= '0;
            for (int p = 0; p < `N_PHASES; p++) begin
                dead_time_reg[p]   <= '0;
                period_reg[p]      <= '0;
                phase_shift_reg[p] <= '0;
                duty_reg[p]        <= '0;
            end
        end else begin
            // One idle cycle after every accepted write
            write_ready <= !write_accept;
            if (write_accept) begin
                case (write_field)
                    field_control:     control_reg <= write_data;
                    field_dead_time:   dead_time_reg[write_phase] <= write_data[15:0];
                    field_period:      period_reg[write_phase] <= write_data[15:0];
                    field_phase_shift: phase_shift_reg[write_phase] <= write_data[15:0];
                    field_duty:        duty_reg[write_phase] <= write_data[15:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (read_field)
            field_control:     read_data = control_reg;
            field_dead_time:   read_data = bus_data_t'(dead_time_reg[read_phase]);
            field_period:      read_data = bus_data_t'(period_reg[read_phase]);
            field_phase_shift: read_data = bus_data_t'(phase_shift_reg[read_phase]);
            field_duty:        read_data = bus_data_t'(duty_reg[read_phase]);
            default:           read_data = '0;
        endcase
    end

endmodule

//--- hdl/buck_control_top.sv
`timescale 1ns/1ns
`include "buck_config.svh"

module buck_control_top (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   start,
    input  logic                   stop,
    input  logic                   update,
    input  buck_pkg::phase_value_t dead_time,
    input  buck_pkg::phase_value_t period,
    input  buck_pkg::phase_value_t duty [`N_PHASES],
    input  buck_pkg::phase_value_t phase_shifts [`N_PHASES],
    input  buck_pkg::bus_address_t read_address,
    output buck_pkg::bus_data_t    read_data,
    output logic                   modulator_status,
    output logic                   duty_echo_valid,
    output buck_pkg::phase_index_t duty_echo_phase,
    output buck_pkg::phase_value_t duty_echo_value
);
    import buck_pkg::*;

    logic         config_done;
    logic         sequencer_valid;
    logic         sequencer_ready;
    bus_address_t sequencer_address;
    bus_data_t    sequencer_data;
    logic         core_valid;
    logic         core_ready;
    bus_address_t core_address;
    bus_data_t    core_data;
    logic         bus_valid;
    logic         bus_ready;
    bus_address_t bus_address;
    bus_data_t    bus_data;

    pwm_config_sequencer sequencer_i (
        .clock         (clock),
        .reset         (reset),
        .start         (start),
        .dead_time     (dead_time),
        .write_valid   (sequencer_valid),
        .write_address (sequencer_address),
        .write_data    (sequencer_data),
        .write_ready   (sequencer_ready),
        .config_done   (config_done)
    );

    buck_operating_core core_i (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .config_done      (config_done),
        .period           (period),
        .duty             (duty),
        .phase_shifts     (phase_shifts),
        .write_valid      (core_valid),
        .write_address    (core_address),
        .write_data       (core_data),
        .write_ready      (core_ready),
        .modulator_status (modulator_status),
        .duty_echo_valid  (duty_echo_valid),
        .duty_echo_phase  (duty_echo_phase),
        .duty_echo_value  (duty_echo_value)
    );

    // Both writers share the single write port of the bank
    register_write_arbiter arbiter_i (
        .sequencer_valid   (sequencer_valid),
        .sequencer_address (sequencer_address),
        .sequencer_data    (sequencer_data),
        .sequencer_ready   (sequencer_ready),
        .core_valid        (core_valid),
        .core_address      (core_address),
        .core_data         (core_data),
        .core_ready        (core_ready),
        .bus_valid         (bus_valid),
        .bus_address       (bus_address),
        .bus_data          (bus_data),
        .bus_ready         (bus_ready)
    );

    pwm_register_bank bank_i (
        .clock         (clock),
        .reset         (reset),
        .write_valid   (bus_valid),
        .write_address (bus_address),
        .write_data    (bus_data),
        .write_ready   (bus_ready),
        .read_address  (read_address),
        .read_data     (read_data)
    );

endmodule

//--- tests/buck_control_tb.sv
`timescale 1ns/1ns
`include "buck_config.svh"

module buck_control_tb;
    import buck_pkg::*;

    localparam int ROUNDS     = 5;
    localparam int POLL_LIMIT = 60;

    logic         clock;
    logic         reset;
    logic         start;
    logic         stop;
    logic         update;
    phase_value_t dead_time;
    phase_value_t period;
    phase_value_t duty [`N_PHASES];
    phase_value_t phase_shifts [`N_PHASES];
    bus_address_t read_address;
    bus_data_t    read_data;
    logic         modulator_status;
    logic         duty_echo_valid;
    phase_index_t duty_echo_phase;
    phase_value_t duty_echo_value;

    integer       seed;
    string        test_name;

    // Register map as the host should see it
    bus_data_t    model_control;
    phase_value_t model_dead_time [`N_PHASES];
    phase_value_t model_period [`N_PHASES];
    phase_value_t model_shift [`N_PHASES];
    phase_value_t model_duty [`N_PHASES];

    phase_index_t echo_phases [$];
    phase_value_t echo_values [$];

    buck_control_top dut_i (
        .clock            (clock),
        .reset            (reset),
        .start            (start),
        .stop             (stop),
        .update           (update),
        .dead_time        (dead_time),
        .period           (period),
        .duty             (duty),
        .phase_shifts     (phase_shifts),
        .read_address     (read_address),
        .read_data        (read_data),
        .modulator_status (modulator_status),
        .duty_echo_valid  (duty_echo_valid),
        .duty_echo_phase  (duty_echo_phase),
        .duty_echo_value  (duty_echo_value)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // Echo pulses are registered, so the falling edge sees them settled
    always @(negedge clock) begin
        if (reset === 1'b1 && duty_echo_valid === 1'b1) begin
            echo_phases.push_back(duty_echo_phase);
            echo_values.push_back(duty_echo_value);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Register map helpers

    function automatic bus_address_t register_address(input int phase, input int field);
        int offset;
        case (field)
            0:       offset = `DEAD_TIME_OFFSET;
            1:       offset = `PERIOD_OFFSET;
            2:       offset = `PHASE_SHIFT_OFFSET;
            default: offset = `DUTY_OFFSET;
        endcase
        // Phase p lives in block p + 1, each block is 256 bytes
        return `PWM_BASE_ADDR + bus_address_t'(offset) + bus_address_t'((phase + 1) * 256);
    endfunction

    function automatic string field_name(input int field);
        case (field)
            0:       return "dead time";
            1:       return "period";
            2:       return "phase shift";
            default: return "duty";
        endcase
    endfunction

    function automatic bus_data_t model_value(input int phase, input int field);
        case (field)
            0:       return bus_data_t'(model_dead_time[phase]);
            1:       return bus_data_t'(model_period[phase]);
            2:       return bus_data_t'(model_shift[phase]);
            default: return bus_data_t'(model_duty[phase]);
        endcase
    endfunction

    function automatic phase_value_t random_value();
        return phase_value_t'($random(seed));
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking and reporting

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check_value(input string what, input bus_data_t expected,
                               input bus_data_t actual);
        assert (actual === expected) else begin
            stop_with_failure($sformatf("** Error [%s] %s: expected 0x%08h, actual 0x%08h",
                                        test_name, what, expected, actual));
        end
    endtask

    task automatic read_register(input bus_address_t address, output bus_data_t value);
        @(posedge clock);
        #1 read_address = address;
        #2 value = read_data;
    endtask

    task automatic registers_match(output logic match);
        bus_data_t value;
        match = 1'b1;
        read_register(`PWM_BASE_ADDR, value);
        if (value !== model_control) match = 1'b0;
        for (int p = 0; p < `N_PHASES; p++) begin
            for (int f = 0; f < 4; f++) begin
                read_register(register_address(p, f), value);
                if (value !== model_value(p, f)) match = 1'b0;
            end
        end
    endtask

    task automatic check_registers();
        bus_data_t value;
        read_register(`PWM_BASE_ADDR, value);
        check_value("control register", model_control, value);
        for (int p = 0; p < `N_PHASES; p++) begin
            for (int f = 0; f < 4; f++) begin
                read_register(register_address(p, f), value);
                check_value($sformatf("%s of phase %0d", field_name(f), p),
                            model_value(p, f), value);
            end
        end
    endtask

    // Polls the read port until the whole map equals the model
    task automatic wait_for_registers();
        logic match;
        match = 1'b0;
        for (int poll = 0; poll < POLL_LIMIT && !match; poll++) begin
            registers_match(match);
        end
        if (!match) begin
            check_registers();
        end
        assert (match) else begin
            stop_with_failure($sformatf("Timeout in %s: register map never reached the model",
                                        test_name));
        end
    endtask

    task automatic wait_for_status(input logic level);
        int cycles;
        cycles = 0;
        while (modulator_status !== level && cycles < POLL_LIMIT * 20) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        assert (modulator_status === level) else begin
            stop_with_failure($sformatf("Timeout in %s: modulator_status never went to %0b",
                                        test_name, level));
        end
    endtask

    task automatic check_duty_echoes();
        check_value("duty echo count", bus_data_t'(`N_PHASES), bus_data_t'(echo_phases.size()));
        for (int i = 0; i < `N_PHASES; i++) begin
            check_value($sformatf("duty echo %0d phase", i), bus_data_t'(i),
                        bus_data_t'(echo_phases[i]));
            check_value($sformatf("duty echo %0d value", i), bus_data_t'(model_duty[i]),
                        bus_data_t'(echo_values[i]));
        end
        echo_phases.delete();
        echo_values.delete();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus

    task automatic drive_random_inputs();
        @(posedge clock);
        #1;
        dead_time = random_value();
        period    = random_value();
        for (int p = 0; p < `N_PHASES; p++) begin
            duty[p]         = random_value();
            phase_shifts[p] = random_value();
        end
    endtask

    task automatic pulse_inputs(input logic do_start, input logic do_stop,
                                input logic do_update);
        @(posedge clock);
        #1;
        start  = do_start;
        stop   = do_stop;
        update = do_update;
        @(posedge clock);
        #1;
        start  = 1'b0;
        stop   = 1'b0;
        update = 1'b0;
    endtask

    task automatic load_model(input logic all_values);
        for (int p = 0; p < `N_PHASES; p++) begin
            if (all_values) begin
                model_dead_time[p] = dead_time;
                model_period[p]    = period;
            end
            model_shift[p] = phase_shifts[p];
            model_duty[p]  = duty[p];
        end
    endtask

    initial begin
        seed          = 32'h47d1;
        reset         = 1'b0;
        start         = 1'b0;
        stop          = 1'b0;
        update        = 1'b0;
        dead_time     = '0;
        period        = '0;
        read_address  = '0;
        model_control = '0;
        for (int p = 0; p < `N_PHASES; p++) begin
            duty[p]         = '0;
            phase_shifts[p] = '0;
        end
        load_model(1'b1);

        test_name = "reset";
        repeat (2) @(posedge clock);
        #1 reset = 1'b1;
        check_value("modulator status", 32'd0, bus_data_t'(modulator_status));
        check_registers();

        for (int round = 1; round <= ROUNDS; round++) begin
            test_name = $sformatf("start round %0d", round);
            drive_random_inputs();
            load_model(1'b1);
            model_control = `MODULATOR_ON_WORD;
            pulse_inputs(1'b1, 1'b0, 1'b0);
            wait_for_status(1'b1);
            wait_for_registers();
            check_duty_echoes();

            // Only shifts and duties may follow the new inputs while the modulator runs
            test_name = $sformatf("update round %0d", round);
            drive_random_inputs();
            load_model(1'b0);
            pulse_inputs(1'b0, 1'b0, 1'b1);
            wait_for_registers();
            check_value("modulator status", 32'd1, bus_data_t'(modulator_status));
            check_duty_echoes();

            test_name = $sformatf("stop round %0d", round);
            pulse_inputs(1'b0, 1'b1, 1'b0);
            wait_for_status(1'b0);
            model_control = '0;
            wait_for_registers();

            // With the modulator off an update must leave the map alone
            test_name = $sformatf("update after stop round %0d", round);
            drive_random_inputs();
            pulse_inputs(1'b0, 1'b0, 1'b1);
            repeat (40) @(posedge clock);
            #1;
            check_value("modulator status", 32'd0, bus_data_t'(modulator_status));
            check_value("duty echo count", 32'd0, bus_data_t'(echo_phases.size()));
            check_registers();
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
hdl/buck_pkg.sv
hdl/pwm_config_sequencer.sv
hdl/buck_operating_core.sv
hdl/register_write_arbiter.sv
hdl/pwm_register_bank.sv
hdl/buck_control_top.sv
tests/buck_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module buck_control_tb -o buck_control_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/buck_control_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TEST OK"; then
    exit 0
fi
echo "Pass message not found in the simulation output"
exit 1
